//--- Bender.yml
package:
  name: pool_engine

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/pool_data_pkg.sv
      - source/pool_ctrl_pkg.sv
      - source/pool_ifs.sv
      - source/sample_fifo.sv
      - source/magnitude_comparator.sv
      - source/window_counter.sv
      - source/max_accumulator.sv
      - source/pool_fsm.sv
      - source/pool_engine.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/pool_engine_tb.sv

//--- bench/pool_engine_tb.sv
`timescale 1ns/1ps
`include "pool_cfg.svh"

module pool_engine_tb;
    import pool_data_pkg::*;

    localparam int MAX_ROWS      = 16;
    localparam int MODE_BURST    = 0;
    localparam int MODE_GAPPED   = 1;
    localparam int MODE_OVERFILL = 2;
    localparam int WAIT_LIMIT    = 200;
    localparam int PUSH_LIMIT    = 1000;
    localparam int FIFO_DEPTH    = 1 << `POOL_FIFO_AW;
    localparam sample_t DROP_MARK = {1'b0, {(`POOL_SAMPLE_W-1){1'b1}}}; // would win any window

    logic    clk;
    logic    rst;
    logic    push;
    sample_t push_data;
    logic    in_full;
    kernel_t kernel_size;
    sample_t pool_max;
    logic    pool_done;

    integer  seed;
    int      num_rows;
    int      pass_count;
    int      fail_count;
    int      done_count = 0;
    bit      timed_out;
    string   name_tab [MAX_ROWS];
    int      kernel_tab [MAX_ROWS];
    int      mode_tab [MAX_ROWS];
    sample_t sample_tab [MAX_ROWS][8];
    sample_t accepted [$]; // samples the FIFO took in the overfill window

    pool_engine i_pool_engine (
        .clk         (clk),
        .rst         (rst),
        .push        (push),
        .push_data   (push_data),
        .in_full     (in_full),
        .kernel_size (kernel_size),
        .pool_max    (pool_max),
        .pool_done   (pool_done)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (pool_done) done_count <= done_count + 1;
    end

    task automatic set_row(input string name, input int k, input int mode, input int s0,
                           input int s1, input int s2, input int s3, input int s4,
                           input int s5, input int s6, input int s7);
        int vals [8];
        vals = '{s0, s1, s2, s3, s4, s5, s6, s7};
        name_tab[num_rows]   = name;
        kernel_tab[num_rows] = k;
        mode_tab[num_rows]   = mode;
        for (int i = 0; i < 8; i++) sample_tab[num_rows][i] = sample_t'(vals[i]);
        num_rows++;
    endtask

    task automatic fill_table();
        set_row("burst_k1", 1, MODE_BURST, 42, 0, 0, 0, 0, 0, 0, 0);
        set_row("burst_k2", 2, MODE_BURST, 7, 19, 0, 0, 0, 0, 0, 0);
        set_row("burst_k4", 4, MODE_BURST, 300, 12, 301, 5, 0, 0, 0, 0);
        set_row("burst_k8", 8, MODE_BURST, 1, 900, 23, 899, 4000, 17, 3999, 2);
        set_row("all_negative", 4, MODE_BURST, -20, -3, -400, -7, 0, 0, 0, 0);
        set_row("with_min", 3, MODE_BURST, -32768, -32768, -1, 0, 0, 0, 0, 0);
        set_row("only_min", 2, MODE_BURST, -32768, -32768, 0, 0, 0, 0, 0, 0);
        set_row("sign_wrap", 4, MODE_BURST, -1, 32767, -32768, 5, 0, 0, 0, 0);
        set_row("gapped_k8", 8, MODE_GAPPED, -50, 70, -90, 65, 12, 71, -3, 0);
        set_row("gapped_neg", 5, MODE_GAPPED, -9, -8, -100, -8, -30, 0, 0, 0);
        set_row("kernel_zero", 0, MODE_BURST, -5, 100, 200, 300, 0, 0, 0, 0);
        set_row("overfill", 40, MODE_OVERFILL, -300, 1200, 45, -7, 999, 1201, -32768, 600);
        set_row("equal_max_a", 3, MODE_BURST, 500, 500, 20, 0, 0, 0, 0, 0);
        set_row("equal_max_b", 3, MODE_BURST, 500, 10, 500, 0, 0, 0, 0, 0);
        set_row("decreasing_a", 2, MODE_BURST, -10, 900, 0, 0, 0, 0, 0, 0);
        set_row("decreasing_b", 2, MODE_BURST, -500, -20, 0, 0, 0, 0, 0, 0);
    endtask

    // called on a falling edge, returns on the next one
    task automatic push_sample(input sample_t value);
        push      = 1'b1;
        push_data = value;
        @(negedge clk);
        push      = 1'b0;
    endtask

    function automatic sample_t largest(input sample_t vals [$]);
        sample_t m;
        m = vals[0];
        foreach (vals[i]) if (vals[i] > m) m = vals[i]; // signed compare
        return m;
    endfunction

    task automatic run_row(input int row);
        int      n;
        int      gap;
        int      base;
        int      waited;
        int      guard;
        int      at_full;
        bit      seen_full;
        bit      done_seen;
        bit      ok;
        sample_t expected;
        sample_t got;
        ok          = 1'b1;
        base        = done_count;
        kernel_size = kernel_t'(kernel_tab[row]);
        n           = (kernel_tab[row] == 0) ? 1 : kernel_tab[row];
        accepted.delete();
        seen_full = 1'b0;
        at_full   = 0;
        guard     = 0;
        if (mode_tab[row] == MODE_OVERFILL) begin
            while (accepted.size() < n && guard < PUSH_LIMIT) begin
                if (in_full) begin
                    if (!seen_full) at_full = accepted.size();
                    seen_full = 1'b1;
                    push_sample(DROP_MARK); // lost if the FIFO drops it
                end else begin
                    accepted.push_back(sample_tab[row][accepted.size() % 8]);
                    push_sample(accepted[$]);
                end
                guard++;
            end
        end else begin
            for (int i = 0; i < n; i++) begin
                accepted.push_back(sample_tab[row][i]);
                push_sample(sample_tab[row][i]);
                if (mode_tab[row] == MODE_GAPPED && i < n - 1) begin
                    gap = 3 + ($unsigned($random(seed)) % 8); // long enough to drain the FIFO
                    repeat (gap) @(negedge clk);
                end
            end
        end
        expected  = largest(accepted);
        done_seen = 1'b0;
        waited    = 0;
        while (!done_seen && waited < WAIT_LIMIT) begin
            if (pool_done) begin
                done_seen = 1'b1;
                got       = pool_max;
            end else begin
                @(negedge clk);
                waited++;
            end
        end
        if (!done_seen) begin
            $display("%s: pool_done did not arrive within %0d cycles", name_tab[row], WAIT_LIMIT);
            fail_count++;
            timed_out = 1'b1;
        end else begin
            @(negedge clk);
            if (got !== expected) begin
                $display("ERROR %s: expected %0d, actual %0d", name_tab[row], expected, got);
                ok = 1'b0;
            end
            if (done_count - base != 1 || pool_done) begin
                $display("%s: saw %0d pool_done pulses instead of one", name_tab[row],
                         done_count - base);
                ok = 1'b0;
            end
            if (mode_tab[row] == MODE_OVERFILL && !seen_full) begin
                $display("%s: in_full never went high", name_tab[row]);
                ok = 1'b0;
            end
            if (mode_tab[row] == MODE_OVERFILL && seen_full && at_full < FIFO_DEPTH) begin
                $display("%s: in_full rose after only %0d samples", name_tab[row], at_full);
                ok = 1'b0;
            end
            if (ok) begin
                pass_count++;
                $display("ok    %s: max %0d", name_tab[row], got);
            end else begin
                fail_count++;
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        push        = 1'b0;
        push_data   = '0;
        kernel_size = kernel_t'(1);
        seed        = 99025;
        num_rows    = 0;
        pass_count  = 0;
        fail_count  = 0;
        timed_out   = 1'b0;
        fill_table();
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (in_full !== 1'b0 || pool_done !== 1'b0) begin
            $display("reset: in_full or pool_done is not low after reset");
            fail_count++;
        end else begin
            pass_count++;
            $display("ok    reset");
        end
        for (int r = 0; r < num_rows && !timed_out; r++) run_row(r);
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- include/pool_cfg.svh
`ifndef POOL_CFG_SVH
`define POOL_CFG_SVH

// width of one signed sample word
`define POOL_SAMPLE_W 16

// input FIFO address width, the depth is 2**POOL_FIFO_AW
`define POOL_FIFO_AW 4

// cycles from a compare request to its result, 1 to 4 are supported
`define POOL_CMP_LAT 2

`endif

//--- pool_engine.f
+incdir+include
source/pool_data_pkg.sv
source/pool_ctrl_pkg.sv
source/pool_ifs.sv
source/sample_fifo.sv
source/magnitude_comparator.sv
source/window_counter.sv
source/max_accumulator.sv
source/pool_fsm.sv
source/pool_engine.sv
bench/pool_engine_tb.sv

//--- source/magnitude_comparator.sv
`timescale 1ns/1ps
`include "pool_cfg.svh"

module magnitude_comparator (
    input logic        clk,
    input logic        rst,
    cmp_if.comparator  cmp
);

    logic [`POOL_CMP_LAT-1:0] valid_pipe;
    logic [`POOL_CMP_LAT-1:0] gt_pipe;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= cmp.nd;
            for (int i = 1; i < `POOL_CMP_LAT; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        gt_pipe[0] <= (cmp.a > cmp.b); // both operands are signed
        for (int i = 1; i < `POOL_CMP_LAT; i++) begin
            gt_pipe[i] <= gt_pipe[i-1];
        end
    end

    assign cmp.gt  = gt_pipe[`POOL_CMP_LAT-1];
    assign cmp.rdy = valid_pipe[`POOL_CMP_LAT-1];

    // operands are sampled with the request and must be known then
    a_known_operands: assert property (@(posedge clk) disable iff (rst)
        cmp.nd |-> !$isunknown({cmp.a, cmp.b}));

endmodule

//--- source/max_accumulator.sv
`timescale 1ns/1ps

module max_accumulator (
    input  logic                   clk,
    input  logic                   rst,
    input  pool_data_pkg::sample_t sample,
    input  logic                   sample_valid,
    input  logic                   first,
    cmp_if.requester               cmp,
    output logic                   cmp_rdy,
    output pool_data_pkg::sample_t max_value
);
    import pool_data_pkg::*;

    sample_t cand_q;   // sample under compare
    sample_t run_q;    // running maximum of the open window
    sample_t result_q; // maximum of the last closed window

    assign cmp.a   = sample;
    assign cmp.b   = first ? SAMPLE_MIN : run_q;
    assign cmp.nd  = sample_valid;
    assign cmp_rdy = cmp.rdy;

    always_ff @(posedge clk) begin
        if (sample_valid) cand_q <= sample;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run_q    <= '0;
            result_q <= '0;
        end else begin
            // first also takes a sample equal to SAMPLE_MIN, which never compares greater
            if (cmp.rdy && (cmp.gt || first)) run_q <= cand_q;
            if (first) result_q <= run_q;
        end
    end

    // first is high from window close until the next window's first compare returns
    assign max_value = first ? run_q : result_q;

endmodule

//--- source/pool_ctrl_pkg.sv
package pool_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE,     // waits for data and latches the window length
        FETCH,    // issues one FIFO read
        WAIT_CMP, // waits for the compare of the fetched sample
        FINISH    // window closed, result valid
    } pool_state_t;

endpackage

//--- source/pool_data_pkg.sv
`include "pool_cfg.svh"

package pool_data_pkg;

    typedef logic signed [`POOL_SAMPLE_W-1:0] sample_t; // one signed sample

    typedef logic [7:0] kernel_t; // window length, also the counter width

    // start value of every window maximum
    localparam sample_t SAMPLE_MIN = {1'b1, {(`POOL_SAMPLE_W-1){1'b0}}};

endpackage

//--- source/pool_engine.sv
`timescale 1ns/1ps

module pool_engine (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push,
    input  pool_data_pkg::sample_t push_data,
    output logic                   in_full,
    input  pool_data_pkg::kernel_t kernel_size,
    output pool_data_pkg::sample_t pool_max,
    output logic                   pool_done
);

    logic cnt_clear;
    logic cnt_step;
    logic last;
    logic first;
    logic cmp_rdy;

    fifo_rd_if fifo_rd ();
    cmp_if     cmp ();

    sample_fifo i_sample_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .full      (in_full),
        .rd        (fifo_rd.provider)
    );

    pool_fsm i_pool_fsm (
        .clk       (clk),
        .rst       (rst),
        .rd        (fifo_rd.consumer),
        .cnt_clear (cnt_clear),
        .cnt_step  (cnt_step),
        .first     (first),
        .last      (last),
        .cmp_rdy   (cmp_rdy),
        .pool_done (pool_done)
    );

    window_counter i_window_counter (
        .clk         (clk),
        .rst         (rst),
        .clear       (cnt_clear),
        .step        (cnt_step),
        .kernel_size (kernel_size),
        .last        (last)
    );

    max_accumulator i_max_accumulator (
        .clk          (clk),
        .rst          (rst),
        .sample       (fifo_rd.rd_data),
        .sample_valid (fifo_rd.rd_valid),
        .first        (first),
        .cmp          (cmp.requester),
        .cmp_rdy      (cmp_rdy),
        .max_value    (pool_max)
    );

    magnitude_comparator i_magnitude_comparator (
        .clk (clk),
        .rst (rst),
        .cmp (cmp.comparator)
    );

endmodule

//--- source/pool_fsm.sv
`timescale 1ns/1ps

module pool_fsm (
    input  logic          clk,
    input  logic          rst,
    fifo_rd_if.consumer   rd,
    output logic          cnt_clear,
    output logic          cnt_step,
    output logic          first,
    input  logic          last,
    input  logic          cmp_rdy,
    output logic          pool_done
);
    import pool_ctrl_pkg::*;

    pool_state_t state_q;
    pool_state_t state_d;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
            first   <= 1'b1;
        end else begin
            state_q <= state_d;
            if (cmp_rdy) first <= last; // the next compare opens a new window after the last one
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (!rd.empty) state_d = FETCH;
            end
            FETCH: begin
                if (!rd.empty) state_d = WAIT_CMP; // an empty FIFO stalls here
            end
            WAIT_CMP: begin
                if (cmp_rdy) state_d = last ? FINISH : FETCH;
            end
            FINISH: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign rd.rd_en  = (state_q == FETCH) && !rd.empty;
    assign cnt_clear = (state_q == IDLE); // window length is latched here
    assign cnt_step  = (state_q == WAIT_CMP) && cmp_rdy;
    assign pool_done = (state_q == FINISH);

    // a compare result may only return while a fetched sample is pending
    a_rdy_when_waiting: assert property (@(posedge clk) disable iff (rst)
        cmp_rdy |-> (state_q == WAIT_CMP));

endmodule

//--- source/pool_ifs.sv
`timescale 1ns/1ps

interface fifo_rd_if;
    import pool_data_pkg::*;

    logic    rd_en;
    logic    empty;
    sample_t rd_data;
    logic    rd_valid; // one cycle after rd_en, qualifies rd_data

    modport consumer (output rd_en, input empty, rd_data, rd_valid);
    modport provider (input rd_en, output empty, rd_data, rd_valid);
endinterface

interface cmp_if;
    import pool_data_pkg::*;

    sample_t a;
    sample_t b;
    logic    nd;  // new compare request
    logic    gt;  // a > b, valid with rdy
    logic    rdy;

    modport requester (output a, b, nd, input gt, rdy);
    modport comparator (input a, b, nd, output gt, rdy);
endinterface

//--- source/sample_fifo.sv
`timescale 1ns/1ps
`include "pool_cfg.svh"

module sample_fifo (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push,
    input  pool_data_pkg::sample_t push_data,
    output logic                   full,
    fifo_rd_if.provider            rd
);
    import pool_data_pkg::*;

    localparam int DEPTH = 1 << `POOL_FIFO_AW;

    sample_t                  mem [DEPTH];
    logic [`POOL_FIFO_AW-1:0] wr_ptr;
    logic [`POOL_FIFO_AW-1:0] rd_ptr;
    logic [`POOL_FIFO_AW:0]   count;
    logic                     do_push;
    logic                     do_read;

    assign do_push  = push && !full;        // pushes into a full buffer are lost
    assign do_read  = rd.rd_en && !rd.empty;
    assign full     = count[`POOL_FIFO_AW]; // only set when count equals DEPTH
    assign rd.empty = (count == '0);

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
        if (do_read) rd.rd_data <= mem[rd_ptr];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            rd.rd_valid <= 1'b0;
        end else begin
            rd.rd_valid <= do_read;
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_read) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // push and read together leave it unchanged
            endcase
        end
    end

    // the consumer must never read from an empty buffer
    a_no_read_when_empty: assert property (@(posedge clk) disable iff (rst)
        rd.rd_en |-> !rd.empty);

endmodule

//--- source/window_counter.sv
`timescale 1ns/1ps

module window_counter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clear,
    input  logic                   step,
    input  pool_data_pkg::kernel_t kernel_size,
    output logic                   last
);
    import pool_data_pkg::*;

    kernel_t size_q;
    kernel_t count_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            size_q  <= kernel_t'(1);
            count_q <= '0;
        end else if (clear) begin
            size_q  <= (kernel_size == '0) ? kernel_t'(1) : kernel_size; // 0 acts as 1
            count_q <= '0;
        end else if (step) begin
            count_q <= count_q + kernel_t'(1);
        end
    end

    assign last = (count_q == size_q - kernel_t'(1)); // the sample in flight closes the window

endmodule
